// ==== include/cfi_params.svh ====
// widths and field positions follow the RV32 I-type encoding of the landing marker
// the stack depth must be a power of two below 2**CFI_PTR_W

`ifndef CFI_PARAMS_SVH
`define CFI_PARAMS_SVH

// datapath widths
`define CFI_XLEN 32
`define CFI_REG_W 5
`define CFI_IMM_W 12

// shadow stack size and depth counter width
`define CFI_STACK_DEPTH 8
`define CFI_PTR_W 5

// link registers that mark a call or a return
`define CFI_REG_RA 5'd1
`define CFI_REG_T0 5'd5

// landing marker immediate layout
`define CFI_MARK_TAG 2'd2
`define CFI_VARIADIC_BIT 11
`define CFI_ARGS_LSB 2
`define CFI_ARGS_MSB 10
`define CFI_ARGCNT_W (`CFI_ARGS_MSB - `CFI_ARGS_LSB + 1)
`define CFI_ARGS_UNSET 9'h1ff

// length of the halt window after a trap
`define CFI_HALT_CYCLES 2

`endif

// ==== hw/cfi_pkg.sv ====
// types shared by the guard stages
// op_kind_e must match the encoding the core uses on its retire port

`default_nettype none

`include "cfi_params.svh"

package cfi_pkg;

    // plain vectors with a meaning
    typedef logic [`CFI_XLEN-1:0] addr_t;
    typedef logic [`CFI_REG_W-1:0] regnum_t;
    typedef logic [`CFI_IMM_W-1:0] imm_t;
    typedef logic [`CFI_ARGCNT_W-1:0] argcnt_t;

    // decoded operation as reported by the core
    typedef enum logic [1:0] {
        OP_JAL   = 2'd0,
        OP_JALR  = 2'd1,
        OP_ADD   = 2'd2,
        OP_OTHER = 2'd3
    } op_kind_e;

    // tag attached by the classify stage
    typedef enum logic [1:0] {
        CLS_OTHER = 2'd0,
        CLS_CALL  = 2'd1,
        CLS_RET   = 2'd2,
        CLS_MARK  = 2'd3
    } instr_class_e;

    // cause reported with a trap, none reads as zero
    typedef enum logic [1:0] {
        CAUSE_NONE         = 2'd0,
        CAUSE_RET_MISMATCH = 2'd1,
        CAUSE_NO_LANDING   = 2'd2
    } cfi_cause_e;

    // both checkers either idle or waiting for the next commit
    typedef enum logic {
        PEND_IDLE = 1'b0,
        PEND_WAIT = 1'b1
    } pend_state_e;

endpackage

`default_nettype wire

// ==== hw/commit_classify.sv ====
// one retire port, faulting commits are dropped here and never reach the checkers
// a JALR that writes a link register is treated as a call even if rs1 is a link register

`default_nettype none

`include "cfi_params.svh"

module commit_classify (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 commit_valid_i,
    input  wire logic                 commit_fault_i,
    input  wire cfi_pkg::addr_t       commit_pc_i,
    input  wire cfi_pkg::op_kind_e    commit_op_i,
    input  wire cfi_pkg::regnum_t     commit_rd_i,
    input  wire cfi_pkg::regnum_t     commit_rs1_i,
    input  wire cfi_pkg::imm_t        commit_imm_i,
    output logic                      cls_valid_o,
    output cfi_pkg::instr_class_e     cls_class_o,
    output cfi_pkg::addr_t            cls_pc_o,
    output cfi_pkg::imm_t             cls_imm_o
);

    logic                  accept;
    logic                  rd_link;
    logic                  rs1_link;
    cfi_pkg::instr_class_e class_d;

    assign accept   = commit_valid_i && !commit_fault_i;
    assign rd_link  = (commit_rd_i == `CFI_REG_RA) || (commit_rd_i == `CFI_REG_T0);
    assign rs1_link = (commit_rs1_i == `CFI_REG_RA) || (commit_rs1_i == `CFI_REG_T0);

    // the order matters, a call wins over a return on the same JALR
    always_comb begin
        class_d = cfi_pkg::CLS_OTHER;
        if ((commit_op_i == cfi_pkg::OP_JAL || commit_op_i == cfi_pkg::OP_JALR) && rd_link) begin
            class_d = cfi_pkg::CLS_CALL;
        end else if (commit_op_i == cfi_pkg::OP_JALR && commit_rd_i == '0 && rs1_link) begin
            class_d = cfi_pkg::CLS_RET;
        end else if (commit_op_i == cfi_pkg::OP_ADD && commit_rd_i == '0 &&
                     commit_rs1_i == '0 && commit_imm_i[1:0] == `CFI_MARK_TAG) begin
            class_d = cfi_pkg::CLS_MARK;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cls_valid_o <= 1'b0;
        end else begin
            cls_valid_o <= accept;
        end
    end

    // payload only moves on an accepted commit
    always_ff @(posedge clk_i) begin
        if (accept) begin
            cls_class_o <= class_d;
            cls_pc_o    <= commit_pc_i;
            cls_imm_o   <= commit_imm_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/return_stack.sv ====
// entries beyond CFI_STACK_DEPTH are counted but not stored, top_valid_o is low then
// a push and a pop in the same cycle replace the top entry

`default_nettype none

`include "cfi_params.svh"

module return_stack (
    input  wire logic            clk_i,
    input  wire logic            rst_ni,
    input  wire logic            push_i,
    input  wire cfi_pkg::addr_t  push_addr_i,
    input  wire logic            pop_i,
    output cfi_pkg::addr_t       top_o,
    output logic                 top_valid_o
);

    localparam int IDX_W = $clog2(`CFI_STACK_DEPTH);
    localparam logic [`CFI_PTR_W-1:0] DEPTH_MAX = `CFI_PTR_W'(`CFI_STACK_DEPTH);

    cfi_pkg::addr_t         mem_q [`CFI_STACK_DEPTH];
    logic [`CFI_PTR_W-1:0]  depth_q;
    logic [`CFI_PTR_W-1:0]  depth_pop;
    logic [`CFI_PTR_W-1:0]  depth_d;
    logic [`CFI_PTR_W-1:0]  top_ptr;
    logic [IDX_W-1:0]       top_idx;
    logic                   store;

    ////////////////////////////////////////////////
    // depth counter

    // the pop is applied first so a push can reuse the freed slot
    always_comb begin
        depth_pop = depth_q;
        if (pop_i && depth_q != '0) begin
            depth_pop = depth_q - 1'b1;
        end
        depth_d = depth_pop;
        // saturate instead of wrapping on very deep recursion
        if (push_i && depth_pop != '1) begin
            depth_d = depth_pop + 1'b1;
        end
    end

    assign store = push_i && (depth_pop < DEPTH_MAX);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            depth_q <= '0;
        end else begin
            depth_q <= depth_d;
        end
    end

    ////////////////////////////////////////////////
    // entry storage

    always_ff @(posedge clk_i) begin
        if (store) begin
            mem_q[depth_pop[IDX_W-1:0]] <= push_addr_i;
        end
    end

    // when the depth is in range the low bits of depth - 1 index the top
    assign top_ptr     = depth_q - 1'b1;
    assign top_idx     = top_ptr[IDX_W-1:0];
    assign top_o       = mem_q[top_idx];
    assign top_valid_o = (depth_q != '0) && (depth_q <= DEPTH_MAX);

endmodule

`default_nettype wire

// ==== hw/edge_check.sv ====
// both checkers look only at the next accepted commit after a call or a return
// arg_count_i is sampled on the cycle the landing marker is checked

`default_nettype none

`include "cfi_params.svh"

module edge_check (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic                   cfi_en_i,
    input  wire cfi_pkg::argcnt_t       arg_count_i,
    input  wire logic                   cls_valid_i,
    input  wire cfi_pkg::instr_class_e  cls_class_i,
    input  wire cfi_pkg::addr_t         cls_pc_i,
    input  wire cfi_pkg::imm_t          cls_imm_i,
    output logic                        viol_valid_o,
    output cfi_pkg::cfi_cause_e         viol_cause_o,
    output cfi_pkg::addr_t              viol_pc_o,
    output logic                        arg_count_clr_o
);

    cfi_pkg::pend_state_e  land_state_q;
    cfi_pkg::pend_state_e  land_state_d;
    cfi_pkg::pend_state_e  ret_state_q;
    cfi_pkg::pend_state_e  ret_state_d;

    cfi_pkg::argcnt_t      mark_args;
    logic                  mark_variadic;
    logic                  args_ok;
    logic                  land_check;
    logic                  land_fail;
    logic                  ret_check;
    logic                  ret_ok;
    logic                  ret_fail;

    logic                  push;
    cfi_pkg::addr_t        push_addr;
    logic                  pop;
    cfi_pkg::addr_t        top;
    logic                  top_valid;
    cfi_pkg::cfi_cause_e   cause_d;

    ////////////////////////////////////////////////
    // forward edge, landing marker after a call

    assign mark_args     = cls_imm_i[`CFI_ARGS_MSB:`CFI_ARGS_LSB];
    assign mark_variadic = cls_imm_i[`CFI_VARIADIC_BIT];

    // an unset CSR means a direct call, any marker is accepted then
    always_comb begin
        if (arg_count_i == `CFI_ARGS_UNSET) begin
            args_ok = 1'b1;
        end else if (mark_variadic) begin
            args_ok = (mark_args >= arg_count_i);
        end else begin
            args_ok = (mark_args == arg_count_i);
        end
    end

    assign land_check = cls_valid_i && (land_state_q == cfi_pkg::PEND_WAIT);
    assign land_fail  = land_check && !(cls_class_i == cfi_pkg::CLS_MARK && args_ok);

    ////////////////////////////////////////////////
    // backward edge, shadow stack

    assign push      = cls_valid_i && (cls_class_i == cfi_pkg::CLS_CALL);
    assign push_addr = cls_pc_i + cfi_pkg::addr_t'(4);

    // returns past the stored entries have no reference and pass
    assign ret_check = cls_valid_i && (ret_state_q == cfi_pkg::PEND_WAIT);
    assign ret_ok    = !top_valid || (cls_pc_i == top);
    assign ret_fail  = ret_check && !ret_ok;
    assign pop       = ret_check && ret_ok;

    return_stack u_return_stack (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .push_addr_i (push_addr),
        .pop_i       (pop),
        .top_o       (top),
        .top_valid_o (top_valid)
    );

    // every accepted commit either arms a checker or returns it to idle
    always_comb begin
        land_state_d = land_state_q;
        ret_state_d  = ret_state_q;
        if (cls_valid_i) begin
            land_state_d = (cls_class_i == cfi_pkg::CLS_CALL) ? cfi_pkg::PEND_WAIT
                                                               : cfi_pkg::PEND_IDLE;
            ret_state_d  = (cls_class_i == cfi_pkg::CLS_RET) ? cfi_pkg::PEND_WAIT
                                                              : cfi_pkg::PEND_IDLE;
        end
    end

    // at most one checker is waiting, so only one cause can apply
    always_comb begin
        cause_d = cfi_pkg::CAUSE_NONE;
        if (ret_fail) begin
            cause_d = cfi_pkg::CAUSE_RET_MISMATCH;
        end else if (land_fail) begin
            cause_d = cfi_pkg::CAUSE_NO_LANDING;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            land_state_q    <= cfi_pkg::PEND_IDLE;
            ret_state_q     <= cfi_pkg::PEND_IDLE;
            viol_valid_o    <= 1'b0;
            viol_cause_o    <= cfi_pkg::CAUSE_NONE;
            arg_count_clr_o <= 1'b0;
        end else begin
            land_state_q    <= land_state_d;
            ret_state_q     <= ret_state_d;
            viol_valid_o    <= (ret_fail || land_fail) && cfi_en_i;
            viol_cause_o    <= cause_d;
            arg_count_clr_o <= land_check || !cfi_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cls_valid_i) begin
            viol_pc_o <= cls_pc_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/trap_report.sv ====
// the halt window restarts on every violation, so back to back traps extend it
// cause and tval read zero outside the pulse and the window

`default_nettype none

`include "cfi_params.svh"

module trap_report (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 viol_valid_i,
    input  wire cfi_pkg::cfi_cause_e  viol_cause_i,
    input  wire cfi_pkg::addr_t       viol_pc_i,
    output logic                      trap_valid_o,
    output cfi_pkg::cfi_cause_e       trap_cause_o,
    output cfi_pkg::addr_t            trap_tval_o,
    output logic                      halt_o
);

    localparam int HALT_W = $clog2(`CFI_HALT_CYCLES + 1);

    // cycles of halt still owed after the current one
    logic [HALT_W-1:0] halt_cnt_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            trap_valid_o <= 1'b0;
            trap_cause_o <= cfi_pkg::CAUSE_NONE;
            trap_tval_o  <= '0;
            halt_cnt_q   <= '0;
            halt_o       <= 1'b0;
        end else begin
            trap_valid_o <= viol_valid_i;
            halt_o       <= (halt_cnt_q != '0);

            if (viol_valid_i) begin
                trap_cause_o <= viol_cause_i;
                trap_tval_o  <= viol_pc_i;
                halt_cnt_q   <= HALT_W'(`CFI_HALT_CYCLES);
            end else if (halt_cnt_q != '0) begin
                halt_cnt_q <= halt_cnt_q - 1'b1;
            end else begin
                // window over, the report goes back to zero
                trap_cause_o <= cfi_pkg::CAUSE_NONE;
                trap_tval_o  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/cfi_guard_top.sv ====
// one retire port, no back-pressure, a commit counts only when valid and not faulting
// trap path latency is three cycles from the sampled commit

`default_nettype none

module cfi_guard_top (
    input  wire logic               clk_i,
    input  wire logic               rst_ni,
    input  wire logic               commit_valid_i,
    input  wire cfi_pkg::addr_t     commit_pc_i,
    input  wire cfi_pkg::op_kind_e  commit_op_i,
    input  wire cfi_pkg::regnum_t   commit_rd_i,
    input  wire cfi_pkg::regnum_t   commit_rs1_i,
    input  wire cfi_pkg::imm_t      commit_imm_i,
    input  wire logic               commit_fault_i,
    input  wire logic               cfi_en_i,
    input  wire cfi_pkg::argcnt_t   arg_count_i,
    output logic                    arg_count_clr_o,
    output logic                    trap_valid_o,
    output cfi_pkg::cfi_cause_e     trap_cause_o,
    output cfi_pkg::addr_t          trap_tval_o,
    output logic                    halt_o
);

    // classify to check
    logic                   cls_valid;
    cfi_pkg::instr_class_e  cls_class;
    cfi_pkg::addr_t         cls_pc;
    cfi_pkg::imm_t          cls_imm;

    // check to report
    logic                   viol_valid;
    cfi_pkg::cfi_cause_e    viol_cause;
    cfi_pkg::addr_t         viol_pc;

    commit_classify u_classify (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .commit_valid_i (commit_valid_i),
        .commit_fault_i (commit_fault_i),
        .commit_pc_i    (commit_pc_i),
        .commit_op_i    (commit_op_i),
        .commit_rd_i    (commit_rd_i),
        .commit_rs1_i   (commit_rs1_i),
        .commit_imm_i   (commit_imm_i),
        .cls_valid_o    (cls_valid),
        .cls_class_o    (cls_class),
        .cls_pc_o       (cls_pc),
        .cls_imm_o      (cls_imm)
    );

    edge_check u_check (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .cfi_en_i        (cfi_en_i),
        .arg_count_i     (arg_count_i),
        .cls_valid_i     (cls_valid),
        .cls_class_i     (cls_class),
        .cls_pc_i        (cls_pc),
        .cls_imm_i       (cls_imm),
        .viol_valid_o    (viol_valid),
        .viol_cause_o    (viol_cause),
        .viol_pc_o       (viol_pc),
        .arg_count_clr_o (arg_count_clr_o)
    );

    trap_report u_report (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .viol_valid_i (viol_valid),
        .viol_cause_i (viol_cause),
        .viol_pc_i    (viol_pc),
        .trap_valid_o (trap_valid_o),
        .trap_cause_o (trap_cause_o),
        .trap_tval_o  (trap_tval_o),
        .halt_o       (halt_o)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// free running clock with a 20 ns period, reset held low for the first 16 rising edges

`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        repeat (16) @(posedge clk_o);
        #2 rst_no = 1'b1;
    end

    always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== tests/cfi_guard_properties.sv ====
// timing rules of the trap and halt outputs, sampled on the rising clock edge
// fail_cnt counts the failed assertions, checks with history start at the third edge

`default_nettype none

module cfi_guard_properties (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 cfi_en_i,
    input  wire logic                 arg_count_clr_o,
    input  wire logic                 trap_valid_o,
    input  wire cfi_pkg::cfi_cause_e  trap_cause_o,
    input  wire cfi_pkg::addr_t       trap_tval_o,
    input  wire logic                 halt_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;
    int edges = 0;

    // history is meaningless before the first couple of edges
    always @(posedge clk_i) begin
        if (edges < 3) begin
            edges <= edges + 1;
        end
    end

    // halt covers exactly the two cycles after each trap pulse
    halt_window_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (edges >= 2) |-> (halt_o == ($past(trap_valid_o) || $past(trap_valid_o, 2))))
    else begin
        fail_cnt++;
        $error("halt does not match the two cycles after a trap");
    end

    // the verdict that led to a trap was taken with the guard enabled
    no_trap_disabled_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (edges >= 2 && trap_valid_o) |-> $past(cfi_en_i, 2))
    else begin
        fail_cnt++;
        $error("trap raised while the guard was disabled");
    end

    no_clear_disabled_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (edges >= 2 && $past(rst_ni) && !$past(cfi_en_i)) |-> arg_count_clr_o)
    else begin
        fail_cnt++;
        $error("argument count clear low while the guard was disabled");
    end

    reset_quiet_a: assert property (@(posedge clk_i)
        (edges >= 2 && !$past(rst_ni)) |->
        (!trap_valid_o && trap_cause_o == cfi_pkg::CAUSE_NONE && trap_tval_o == '0 &&
         !halt_o && !arg_count_clr_o))
    else begin
        fail_cnt++;
        $error("outputs not zero during reset");
    end

endmodule

bind cfi_guard_top cfi_guard_properties props0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cfi_en_i        (cfi_en_i),
    .arg_count_clr_o (arg_count_clr_o),
    .trap_valid_o    (trap_valid_o),
    .trap_cause_o    (trap_cause_o),
    .trap_tval_o     (trap_tval_o),
    .halt_o          (halt_o)
);

`default_nettype wire

// ==== tests/cfi_guard_tb.sv ====
// inputs change 2 ns after the rising edge, cfi_en_i and arg_count_i only change between tests
// the reference model expects a trap three cycles and a clear two cycles after a commit cycle

`default_nettype none

`include "cfi_params.svh"

module cfi_guard_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // about 85 commits of at most two cycles each, some 50 idle cycles, reset and margin
    localparam int EST_COMMITS = 90;
    localparam int EST_IDLE = 60;
    localparam int CYCLE_LIMIT = 16 + EST_COMMITS * 2 + EST_IDLE + 100;

    logic clk_i, rst_ni, commit_valid_i, commit_fault_i, cfi_en_i;
    cfi_pkg::addr_t commit_pc_i, trap_tval_o;
    cfi_pkg::op_kind_e commit_op_i;
    cfi_pkg::regnum_t commit_rd_i, commit_rs1_i;
    cfi_pkg::imm_t commit_imm_i;
    cfi_pkg::argcnt_t arg_count_i;
    logic arg_count_clr_o, trap_valid_o, halt_o;
    cfi_pkg::cfi_cause_e trap_cause_o;

    // reference model state
    cfi_pkg::addr_t stk [`CFI_STACK_DEPTH];
    int depth = 0;
    logic land_pend = 1'b0;
    logic ret_pend = 1'b0;
    bit exp_trap [int];
    bit exp_clr [int];
    cfi_pkg::cfi_cause_e exp_cause [int];
    cfi_pkg::addr_t exp_tval [int];
    int cyc = 0;
    int held;
    bit check_on = 1'b0;
    string test_name = "reset";
    logic en_s, ev, ec;
    logic [31:0] lfsr = 32'h3d76_0d97;
    logic [31:0] rnd;

    tb_clock_gen clk_gen0 (.clk_o(clk_i), .rst_no(rst_ni));

    cfi_guard_top dut0 (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp, act);
        $display("FAILED %s %s expected %h actual %h", test_name, name, exp, act);
        abort_run("output does not match the reference model");
    endtask

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic cfi_pkg::imm_t make_mark(input logic variadic, input logic [8:0] args);
        return {variadic, args, 2'b10};
    endfunction

    task automatic apply_model(input cfi_pkg::addr_t pc, input cfi_pkg::op_kind_e op,
                               input cfi_pkg::regnum_t rd, rs1, input cfi_pkg::imm_t imm);
        cfi_pkg::instr_class_e c;
        cfi_pkg::cfi_cause_e cause;
        logic fail, ok, rd_link, rs1_link;
        rd_link  = (rd == 5'd1) || (rd == 5'd5);
        rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);
        c = cfi_pkg::CLS_OTHER;
        if ((op == cfi_pkg::OP_JAL || op == cfi_pkg::OP_JALR) && rd_link) begin
            c = cfi_pkg::CLS_CALL;
        end else if (op == cfi_pkg::OP_JALR && rd == 0 && rs1_link) begin
            c = cfi_pkg::CLS_RET;
        end else if (op == cfi_pkg::OP_ADD && rd == 0 && rs1 == 0 && imm[1:0] == 2'd2) begin
            c = cfi_pkg::CLS_MARK;
        end
        fail  = 1'b0;
        cause = cfi_pkg::CAUSE_NONE;
        if (land_pend) begin
            exp_clr[cyc + 2] = 1'b1;
            if (arg_count_i == 9'h1ff) begin
                ok = 1'b1;
            end else if (imm[11]) begin
                ok = (imm[10:2] >= arg_count_i);
            end else begin
                ok = (imm[10:2] == arg_count_i);
            end
            if (!(c == cfi_pkg::CLS_MARK && ok)) begin
                fail  = 1'b1;
                cause = cfi_pkg::CAUSE_NO_LANDING;
            end
        end
        if (ret_pend) begin
            if (depth >= 1 && depth <= `CFI_STACK_DEPTH && pc != stk[depth - 1]) begin
                fail  = 1'b1;
                cause = cfi_pkg::CAUSE_RET_MISMATCH;
            end else if (depth > 0) begin
                depth--;
            end
        end
        if (c == cfi_pkg::CLS_CALL) begin
            if (depth < `CFI_STACK_DEPTH) begin
                stk[depth] = pc + 32'd4;
            end
            if (depth < (1 << `CFI_PTR_W) - 1) begin
                depth++;
            end
        end
        if (fail && cfi_en_i) begin
            exp_trap[cyc + 3]  = 1'b1;
            exp_cause[cyc + 3] = cause;
            exp_tval[cyc + 3]  = pc;
        end
        land_pend = (c == cfi_pkg::CLS_CALL);
        ret_pend  = (c == cfi_pkg::CLS_RET);
    endtask

    task automatic raw_commit(input logic valid, fault, input cfi_pkg::addr_t pc,
                              input cfi_pkg::op_kind_e op, input cfi_pkg::regnum_t rd, rs1,
                              input cfi_pkg::imm_t imm);
        logic [31:0] gap;
        @(posedge clk_i);
        #2;
        commit_valid_i = valid;
        commit_fault_i = fault;
        commit_pc_i    = pc;
        commit_op_i    = op;
        commit_rd_i    = rd;
        commit_rs1_i   = rs1;
        commit_imm_i   = imm;
        if (valid && !fault) begin
            apply_model(pc, op, rd, rs1, imm);
        end
        take_bits(1, gap);
        if (gap[0]) begin
            @(posedge clk_i);
            #2 commit_valid_i = 1'b0;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #2 commit_valid_i = 1'b0;
        end
    endtask

    task automatic other(input cfi_pkg::addr_t pc);
        raw_commit(1'b1, 1'b0, pc, cfi_pkg::OP_OTHER, 5'd7, 5'd8, 12'h013);
    endtask

    task automatic call(input cfi_pkg::addr_t pc, input cfi_pkg::regnum_t rd);
        raw_commit(1'b1, 1'b0, pc, cfi_pkg::OP_JAL, rd, 5'd0, '0);
    endtask

    task automatic mark(input cfi_pkg::addr_t pc, input logic variadic, input int args);
        raw_commit(1'b1, 1'b0, pc, cfi_pkg::OP_ADD, 5'd0, 5'd0, make_mark(variadic, 9'(args)));
    endtask

    task automatic ret_to(input cfi_pkg::addr_t pc, input cfi_pkg::addr_t target);
        raw_commit(1'b1, 1'b0, pc, cfi_pkg::OP_JALR, 5'd0, 5'd1, '0);
        other(target);
    endtask

    task automatic filler(input int n);
        for (int i = 0; i < n; i++) begin
            take_bits(16, rnd);
            other({14'h0, rnd[15:0], 2'b00});
        end
    endtask

    // the idle cycles keep the new value away from checks still in flight
    task automatic set_args(input logic [8:0] v);
        idle(3);
        arg_count_i = v;
    endtask

    task automatic set_en(input logic v);
        idle(4);
        cfi_en_i = v;
        idle(2);
    endtask

    ////////////////////////////////////////////////
    // output checks against the reference model

    always @(posedge clk_i) begin
        en_s = cfi_en_i;
        #1;
        cyc++;
        if (cyc > CYCLE_LIMIT) begin
            abort_run("timeout: cycle limit reached before the tests ended");
        end
        assert (dut0.props0.fail_cnt == 0)
        else abort_run("a timing property of the guard failed");
        if (check_on) begin
            ev = exp_trap.exists(cyc);
            assert (trap_valid_o == ev)
            else report_mismatch("trap_valid", 32'(ev), 32'(trap_valid_o));
            if (ev) begin
                assert (trap_cause_o == exp_cause[cyc])
                else report_mismatch("trap_cause", 32'(exp_cause[cyc]), 32'(trap_cause_o));
                assert (trap_tval_o == exp_tval[cyc])
                else report_mismatch("trap_tval", exp_tval[cyc], trap_tval_o);
            end else if (exp_trap.exists(cyc - 1) || exp_trap.exists(cyc - 2)) begin
                // the report of the latest trap holds over the halt window
                held = exp_trap.exists(cyc - 1) ? cyc - 1 : cyc - 2;
                assert (trap_cause_o == exp_cause[held])
                else report_mismatch("trap_cause_held", 32'(exp_cause[held]),
                                     32'(trap_cause_o));
                assert (trap_tval_o == exp_tval[held])
                else report_mismatch("trap_tval_held", exp_tval[held], trap_tval_o);
            end else begin
                assert (trap_cause_o == cfi_pkg::CAUSE_NONE)
                else report_mismatch("trap_cause_idle", 32'(cfi_pkg::CAUSE_NONE),
                                     32'(trap_cause_o));
                assert (trap_tval_o == '0)
                else report_mismatch("trap_tval_idle", 32'h0, trap_tval_o);
            end
            ec = exp_clr.exists(cyc) || !en_s;
            assert (arg_count_clr_o == ec)
            else report_mismatch("arg_count_clr", 32'(ec), 32'(arg_count_clr_o));
        end
    end

    ////////////////////////////////////////////////
    // stimulus

    initial begin
        commit_valid_i = 1'b0;
        commit_fault_i = 1'b0;
        commit_pc_i    = '0;
        commit_op_i    = cfi_pkg::OP_OTHER;
        commit_rd_i    = '0;
        commit_rs1_i   = '0;
        commit_imm_i   = '0;
        cfi_en_i       = 1'b1;
        arg_count_i    = `CFI_ARGS_UNSET;
        wait (rst_ni === 1'b1);
        idle(2);
        check_on = 1'b1;

        // direct call, marker, body and a correct return
        test_name = "direct_call";
        call(32'h1000, 5'd1);
        mark(32'h2000, 1'b0, 3);
        filler(5);
        ret_to(32'h2040, 32'h1004);
        idle(2);
        // wrong return target
        test_name = "ret_mismatch";
        call(32'h3000, 5'd5);
        mark(32'h3800, 1'b0, 0);
        ret_to(32'h3810, 32'h5555_0000);
        idle(5);
        // landing rules
        test_name = "landing_rules";
        call(32'h1100, 5'd1);
        other(32'h1200);
        set_args(9'd4);
        call(32'h1300, 5'd1);
        mark(32'h1400, 1'b0, 3);
        call(32'h1500, 5'd5);
        mark(32'h1600, 1'b1, 3);
        call(32'h1700, 5'd1);
        mark(32'h1800, 1'b1, 5);
        call(32'h1900, 5'd1);
        mark(32'h1a00, 1'b0, 4);
        set_args(`CFI_ARGS_UNSET);
        call(32'h1b00, 5'd1);
        mark(32'h1c00, 1'b0, 7);
        idle(4);
        // nesting past the stack, unchecked returns, then checked ones
        test_name = "stack_overflow";
        for (int i = 0; i < 10; i++) begin
            call(32'h4000 + 32'(i) * 32'h40, 5'd1);
            mark(32'h8000 + 32'(i) * 32'h40, 1'b0, i);
        end
        while (depth > `CFI_STACK_DEPTH) begin
            take_bits(20, rnd);
            ret_to(32'h9000, {10'h0, rnd[19:0], 2'b00});
        end
        for (int i = 0; i < 3; i++) begin
            ret_to(32'h9100, stk[depth - 1]);
        end
        ret_to(32'h9200, 32'h0bad_0000);
        idle(5);
        // disabled guard
        test_name = "guard_disabled";
        set_en(1'b0);
        call(32'h5000, 5'd1);
        other(32'h5100);
        ret_to(32'h5200, 32'h5300);
        set_en(1'b1);
        // faulting and invalid commits between call and marker
        test_name = "fault_ignored";
        call(32'h6000, 5'd1);
        raw_commit(1'b1, 1'b1, 32'h6100, cfi_pkg::OP_OTHER, 5'd3, 5'd4, 12'h0);
        raw_commit(1'b0, 1'b0, 32'h6200, cfi_pkg::OP_JAL, 5'd1, 5'd0, 12'h0);
        mark(32'h6300, 1'b0, 1);
        idle(8);

        if (dut0.props0.fail_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run("a timing property failed near the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
hw/cfi_pkg.sv
hw/commit_classify.sv
hw/return_stack.sv
hw/edge_check.sv
hw/trap_report.sv
hw/cfi_guard_top.sv
tests/tb_clock_gen.sv
tests/cfi_guard_properties.sv
tests/cfi_guard_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the guard testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary -sv --assert \
    --top-module cfi_guard_tb \
    -f src.f \
    -o Vcfi_guard_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

# a raised error limit lets the testbench report failed properties itself
sim_out=$(./obj_dir/Vcfi_guard_tb +verilator+error+limit+100 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found"
exit 1
